//--- hw/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define SOC_ADDR_W 16
`define SOC_DATA_W 32

// internal sram, word index from addr[7:2]
`define INT_MEM_WORDS 64
// low words write-protected while boot is set
`define BOOT_WORDS 16

// peripheral map, slave picked by addr[14]
`define N_SLAVES 2
`define UART_BASE 0
`define RST_CTR_BASE 1

// uart
`define TX_FIFO_DEPTH 4
// bit period in clock cycles after reset
`define UART_DIV_RST 8

`endif

//--- hw/soc_pkg.sv
`include "soc_params.svh"

package soc_pkg;

   // request from the bus master, zero wstrb is a read
   typedef struct packed {
      logic                   valid;
      logic [`SOC_ADDR_W-1:0] addr;
      logic [`SOC_DATA_W-1:0] wdata;
      logic [3:0]             wstrb;
   } mem_req_t;

   // response, ready is a one-cycle pulse
   typedef struct packed {
      logic                   ready;
      logic [`SOC_DATA_W-1:0] rdata;
   } mem_rsp_t;

   // uart register offsets, addr[3:2]
   typedef enum logic [1:0] {
      UART_TXDATA = 2'd0,
      UART_STATUS = 2'd1,
      UART_DIV    = 2'd2
   } uart_reg_t;

   // serializer states
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_state_t;

endpackage

//--- hw/int_mem.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module int_mem import soc_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     boot,
   input  mem_req_t req,
   output mem_rsp_t rsp,
   output logic     busy
);

   localparam int IDX_W = $clog2(`INT_MEM_WORDS);

   logic [`SOC_DATA_W-1:0] mem [`INT_MEM_WORDS];
   logic [`SOC_DATA_W-1:0] rdata_q;
   logic [IDX_W-1:0]       clr_idx;
   logic [IDX_W-1:0]       idx;
   logic                   ready_q;
   logic                   accept;
   logic                   wr_en;

   assign idx    = req.addr[IDX_W+1:2];
   assign accept = req.valid && !busy && !ready_q;
   // boot region writes are acknowledged but dropped
   assign wr_en  = accept && (req.wstrb != 4'b0) &&
                   !(boot && (idx < IDX_W'(`BOOT_WORDS)));

   // clear sweep and handshake
   always_ff @(posedge clk) begin
      if (rst) begin
         busy    <= 1'b1;
         clr_idx <= '0;
         ready_q <= 1'b0;
      end else begin
         ready_q <= accept;
         if (busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == IDX_W'(`INT_MEM_WORDS - 1))
               busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (busy) begin
         mem[clr_idx] <= '0;
      end else if (wr_en) begin
         for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b])
               mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
         end
      end
   end

   // read data returns the word before any write in the same access
   always_ff @(posedge clk) begin
      if (accept)
         rdata_q <= mem[idx];
   end

   assign rsp.ready = ready_q;
   assign rsp.rdata = rdata_q;

   // no answer may come out of the clear sweep
   assert property (@(posedge clk) disable iff (rst) busy |-> !rsp.ready);

endmodule

//--- hw/periph_intercon.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module periph_intercon import soc_pkg::*; (
   input  logic                 req_valid,
   input  logic                 sel,
   input  mem_rsp_t             s_rsp [`N_SLAVES],
   output logic [`N_SLAVES-1:0] s_valid,
   output mem_rsp_t             rsp
);

   // one-hot valid towards the selected slave
   always_comb begin
      s_valid      = '0;
      s_valid[sel] = req_valid;
   end

   // response of the selected slave back to the master
   assign rsp = s_rsp[sel];

   // only one slave may see a request at a time
   always_comb begin
      assert ($onehot0(s_valid))
         else $error("periph_intercon: more than one slave selected");
   end

endmodule

//--- hw/tx_fifo.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module tx_fifo #(
   parameter int  DEPTH = `TX_FIFO_DEPTH,
   localparam int CNT_W = $clog2(DEPTH + 1)
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             push,
   input  logic [7:0]       din,
   input  logic             pop,
   output logic [7:0]       dout,
   output logic             full,
   output logic             empty,
   output logic [CNT_W-1:0] count
);

   localparam int PTR_W = $clog2(DEPTH);

   logic [7:0]       buf_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         buf_mem[wr_ptr] <= din;
   end

   // head byte is visible before the pop
   assign dout  = buf_mem[rd_ptr];
   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   assert property (@(posedge clk) disable iff (rst) push |-> !full);
   assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module uart_tx import soc_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  mem_req_t req,
   input  logic     valid,
   output mem_rsp_t rsp,
   output logic     txd,
   input  logic     cts
);

   localparam int CNT_W = $clog2(`TX_FIFO_DEPTH + 1);

   uart_reg_t              reg_sel;
   uart_state_t            state;
   logic                   is_wr;
   logic                   accept;
   logic                   push;
   logic                   pop;
   logic                   full;
   logic                   empty;
   logic                   ready_q;
   logic                   tx_busy;
   logic                   bit_end;
   logic [7:0]             fifo_dout;
   logic [7:0]             shreg;
   logic [CNT_W-1:0]       fifo_count;
   logic [15:0]            div;
   logic [15:0]            div_cnt;
   logic [2:0]             bit_cnt;
   logic [`SOC_DATA_W-1:0] rdata_q;

   assign reg_sel = uart_reg_t'(req.addr[3:2]);
   assign is_wr   = (req.wstrb != 4'b0);
   // txdata writes wait here while the fifo is full
   assign accept  = valid && !ready_q && !(is_wr && reg_sel == UART_TXDATA && full);
   assign push    = accept && is_wr && reg_sel == UART_TXDATA;

   always_ff @(posedge clk) begin
      if (rst) begin
         ready_q <= 1'b0;
         div     <= 16'(`UART_DIV_RST);
      end else begin
         ready_q <= accept;
         if (accept && is_wr && reg_sel == UART_DIV)
            div <= req.wdata[15:0];
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rdata_q <= '0;
         case (reg_sel)
            UART_STATUS: rdata_q[CNT_W:0] <= {fifo_count, tx_busy};
            UART_DIV:    rdata_q[15:0]    <= div;
            default: ;
         endcase
      end
   end

   assign rsp.ready = ready_q;
   assign rsp.rdata = rdata_q;

   tx_fifo u_tx_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (push),
      .din   (req.wdata[7:0]),
      .pop   (pop),
      .dout  (fifo_dout),
      .full  (full),
      .empty (empty),
      .count (fifo_count)
   );

   // 8N1 serializer sending lsb first
   assign tx_busy = (state != TX_IDLE);
   assign pop     = (state == TX_IDLE) && !empty && cts;
   assign bit_end = ({1'b0, div_cnt} + 17'd1 >= {1'b0, div});

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= TX_IDLE;
         div_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               div_cnt <= '0;
               bit_cnt <= '0;
               if (pop)
                  state <= TX_START;
            end
            TX_START: if (bit_end) state <= TX_DATA;
            TX_DATA: begin
               if (bit_end) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     state <= TX_STOP;
               end
            end
            TX_STOP: if (bit_end) state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (pop)
         shreg <= fifo_dout;
      else if (state == TX_DATA && bit_end)
         shreg <= shreg >> 1;
   end

   always_comb begin
      case (state)
         TX_START: txd = 1'b0;
         TX_DATA:  txd = shreg[0];
         default:  txd = 1'b1;
      endcase
   end

endmodule

//--- hw/rst_ctr.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module rst_ctr import soc_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  mem_req_t req,
   input  logic     valid,
   output mem_rsp_t rsp,
   output logic     soft_rst,
   output logic     boot
);

   logic                   ready_q;
   logic                   accept;
   logic [`SOC_DATA_W-1:0] rdata_q;

   assign accept = valid && !ready_q;

   // only the external reset reaches here, so boot survives a soft reset
   always_ff @(posedge clk) begin
      if (rst) begin
         ready_q  <= 1'b0;
         soft_rst <= 1'b0;
         boot     <= 1'b1;
      end else begin
         ready_q  <= accept;
         soft_rst <= 1'b0;
         if (accept && req.wstrb != 4'b0) begin
            boot     <= req.wdata[0];
            soft_rst <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         rdata_q <= {{(`SOC_DATA_W - 1){1'b0}}, boot};
   end

   assign rsp.ready = ready_q;
   assign rsp.rdata = rdata_q;

endmodule

//--- hw/soc_system.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module soc_system import soc_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  mem_req_t bus_req,
   output mem_rsp_t bus_rsp,
   output logic     mem_busy,
   output logic     txd,
   input  logic     cts
);

   logic                 soft_rst;
   logic                 rst_int;
   logic                 boot;
   logic                 p_valid;
   logic [`N_SLAVES-1:0] s_valid;
   mem_req_t             mem_req;
   mem_rsp_t             mem_rsp;
   mem_rsp_t             p_rsp;
   mem_rsp_t             s_rsp [`N_SLAVES];

   assign rst_int = rst | soft_rst;

   // addr msb picks peripherals, otherwise internal sram
   always_comb begin
      mem_req       = bus_req;
      mem_req.valid = 1'b0;
      p_valid       = 1'b0;
      bus_rsp       = mem_rsp;
      if (bus_req.addr[`SOC_ADDR_W-1]) begin
         p_valid = bus_req.valid;
         bus_rsp = p_rsp;
      end else begin
         mem_req.valid = bus_req.valid;
      end
   end

   int_mem u_int_mem (
      .clk  (clk),
      .rst  (rst_int),
      .boot (boot),
      .req  (mem_req),
      .rsp  (mem_rsp),
      .busy (mem_busy)
   );

   periph_intercon u_periph_intercon (
      .req_valid (p_valid),
      .sel       (bus_req.addr[`SOC_ADDR_W-2]),
      .s_rsp     (s_rsp),
      .s_valid   (s_valid),
      .rsp       (p_rsp)
   );

   uart_tx u_uart_tx (
      .clk   (clk),
      .rst   (rst_int),
      .req   (bus_req),
      .valid (s_valid[`UART_BASE]),
      .rsp   (s_rsp[`UART_BASE]),
      .txd   (txd),
      .cts   (cts)
   );

   rst_ctr u_rst_ctr (
      .clk      (clk),
      .rst      (rst),
      .req      (bus_req),
      .valid    (s_valid[`RST_CTR_BASE]),
      .rsp      (s_rsp[`RST_CTR_BASE]),
      .soft_rst (soft_rst),
      .boot     (boot)
   );

   // no target answers a request the master is not holding
   assert property (@(posedge clk) disable iff (rst) bus_rsp.ready |-> bus_req.valid);

endmodule

//--- bench/tb_soc_system.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module tb_soc_system import soc_pkg::*; ();

   localparam int IDX_W      = $clog2(`INT_MEM_WORDS);
   localparam int RST_CYCLES = 16;
   localparam int N_RAND     = 8;
   localparam int N_BYTES    = 8;
   localparam int TEST_DIV   = 4;
   localparam int CTS_HOLD   = 30 * TEST_DIV;
   localparam int N_XFERS    = 64;
   localparam int XFER_LIMIT = 2 * `INT_MEM_WORDS + 20 * TEST_DIV;
   // reset, three clear sweeps, bus traffic, frames, cts hold, margin
   localparam int WATCHDOG_CYCLES = RST_CYCLES + 3 * `INT_MEM_WORDS + N_XFERS * 5 +
                                    N_BYTES * 10 * TEST_DIV + CTS_HOLD + 500;

   // addr[15] selects peripherals and addr[14] picks uart or reset controller
   localparam logic [15:0] TXDATA_ADDR = 16'h8000;
   localparam logic [15:0] STATUS_ADDR = 16'h8004;
   localparam logic [15:0] DIV_ADDR    = 16'h8008;
   localparam logic [15:0] RST_ADDR    = 16'hc000;

   logic        clk;
   logic        rst;
   mem_req_t    bus_req;
   mem_rsp_t    bus_rsp;
   logic        mem_busy;
   logic        txd;
   logic        cts;
   logic [31:0] lfsr = 32'hb207_4238;
   logic [31:0] shadow [`INT_MEM_WORDS];
   logic [7:0]  exp_q [$];
   logic [7:0]  rx_byte;
   int          rx_div;
   int          rx_count;

   soc_system u_soc_system (
      .clk      (clk),
      .rst      (rst),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .mem_busy (mem_busy),
      .txd      (txd),
      .cts      (cts)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
   endtask

   // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [15:0] mem_addr(input logic [IDX_W-1:0] idx);
      return 16'({idx, 2'b00});
   endfunction

   // hold valid until ready and sample the answer away from the edge
   task automatic transfer(input logic [15:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, output logic [31:0] rdata);
      mem_req_t req;
      int       waited;
      req.valid = 1'b1;
      req.addr  = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      @(posedge clk);
      bus_req <= req;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         if (waited > XFER_LIMIT)
            abort_run($sformatf("no ready for the request to address %h", addr));
      end while (!bus_rsp.ready);
      rdata = bus_rsp.rdata;
      @(posedge clk);
      bus_req.valid <= 1'b0;
   endtask

   task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
      logic [31:0] ignored;
      transfer(addr, data, strb, ignored);
   endtask

   task automatic read_check(input string name, input logic [15:0] addr,
                             input logic [31:0] exp);
      logic [31:0] got;
      transfer(addr, 32'h0, 4'h0, got);
      check_value(name, exp, got);
   endtask

   task automatic merge_shadow(input logic [IDX_W-1:0] idx, input logic [31:0] data,
                               input logic [3:0] strb);
      for (int b = 0; b < 4; b++) begin
         if (strb[b])
            shadow[idx][8*b +: 8] = data[8*b +: 8];
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      exp_q.push_back(b);
      write_word(TXDATA_ADDR, {24'h0, b}, 4'h1);
   endtask

   // serial receiver sampling each bit in its middle
   initial begin
      rx_count = 0;
      forever begin
         @(negedge txd);
         repeat (rx_div / 2) @(negedge clk);
         check_value("t5_rx_start", 32'd0, 32'(txd));
         for (int i = 0; i < 8; i++) begin
            repeat (rx_div) @(negedge clk);
            rx_byte = {txd, rx_byte[7:1]};
         end
         repeat (rx_div) @(negedge clk);
         check_value("t5_rx_stop", 32'd1, 32'(txd));
         assert (exp_q.size() != 0)
         else abort_run("a frame arrived while no byte was expected");
         check_value("t5_rx_byte", 32'(exp_q.pop_front()), 32'(rx_byte));
         rx_count++;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run("watchdog expired before the tests finished");
   end

   initial begin
      logic [IDX_W-1:0] idx;
      logic [31:0]      data;
      logic [3:0]       strb;
      int               cycles;
      rst     <= 1'b1;
      bus_req <= '0;
      cts     <= 1'b1;
      rx_div   = `UART_DIV_RST;
      shadow   = '{default: '0};
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;

      // clear sweep length then random reads of zeros
      cycles = 0;
      @(negedge clk);
      while (mem_busy) begin
         cycles++;
         if (cycles > 2 * `INT_MEM_WORDS)
            abort_run("mem_busy never fell after reset");
         @(negedge clk);
      end
      check_value("t1_clear_time", `INT_MEM_WORDS, cycles);
      for (int n = 0; n < N_RAND; n++) begin
         idx = IDX_W'(random_bits(IDX_W));
         read_check("t1_clear_read", mem_addr(idx), shadow[idx]);
      end

      // strobed writes above the boot region
      for (int n = 0; n < 2 * N_RAND; n++) begin
         idx  = IDX_W'(`BOOT_WORDS + int'(random_bits(IDX_W)) %
                       (`INT_MEM_WORDS - `BOOT_WORDS));
         strb = 4'(random_bits(4));
         if (strb == 4'h0)
            strb = 4'hf;
         data = random_bits(32);
         write_word(mem_addr(idx), data, strb);
         merge_shadow(idx, data, strb);
         read_check("t2_strobe", mem_addr(idx), shadow[idx]);
      end

      // boot region locked and then opened by clearing boot
      for (int n = 0; n < 4; n++) begin
         idx = IDX_W'(random_bits(4));
         write_word(mem_addr(idx), random_bits(32), 4'hf);
         read_check("t3_boot_locked", mem_addr(idx), shadow[idx]);
      end
      write_word(RST_ADDR, 32'h0, 4'h1);
      shadow = '{default: '0};
      read_check("t3_boot_flag", RST_ADDR, 32'h0);
      for (int n = 0; n < 4; n++) begin
         idx  = IDX_W'(random_bits(4));
         data = random_bits(32);
         write_word(mem_addr(idx), data, 4'hf);
         merge_shadow(idx, data, 4'hf);
         read_check("t3_boot_open", mem_addr(idx), shadow[idx]);
      end

      // soft reset clears memory and uart while boot keeps its new value
      idx  = IDX_W'(`BOOT_WORDS + int'(random_bits(5)));
      data = random_bits(32);
      write_word(mem_addr(idx), data, 4'hf);
      merge_shadow(idx, data, 4'hf);
      read_check("t4_before", mem_addr(idx), shadow[idx]);
      write_word(DIV_ADDR, 32'd5, 4'hf);
      read_check("t4_div_set", DIV_ADDR, 32'd5);
      write_word(RST_ADDR, 32'h1, 4'h1);
      shadow = '{default: '0};
      read_check("t4_mem_cleared", mem_addr(idx), shadow[idx]);
      read_check("t4_div_reset", DIV_ADDR, `UART_DIV_RST);
      read_check("t4_boot_kept", RST_ADDR, 32'h1);

      // uart fifo filled while cts is low
      rx_div = TEST_DIV;
      write_word(DIV_ADDR, TEST_DIV, 4'hf);
      @(posedge clk);
      cts <= 1'b0;
      for (int n = 0; n < `TX_FIFO_DEPTH; n++)
         send_byte(8'(random_bits(8)));
      read_check("t5_status_full", STATUS_ADDR, `TX_FIFO_DEPTH << 1);
      repeat (CTS_HOLD) begin
         @(negedge clk);
         check_value("t5_cts_hold", 32'd1, 32'(txd));
      end
      @(posedge clk);
      cts <= 1'b1;
      // these writes stall on the full fifo
      for (int n = `TX_FIFO_DEPTH; n < N_BYTES; n++)
         send_byte(8'(random_bits(8)));
      cycles = 0;
      while (rx_count < N_BYTES) begin
         @(negedge clk);
         cycles++;
         if (cycles > 2 * N_BYTES * 10 * TEST_DIV)
            abort_run("not all uart frames were received");
      end
      // rest of the last stop bit
      repeat (TEST_DIV) @(negedge clk);
      read_check("t5_status_idle", STATUS_ADDR, 32'h0);

      $display(">>> PASS");
      $finish;
   end

endmodule

//--- files.f
+incdir+hw
hw/soc_pkg.sv
hw/int_mem.sv
hw/periph_intercon.sv
hw/tx_fifo.sv
hw/uart_tx.sv
hw/rst_ctr.sv
hw/soc_system.sv
bench/tb_soc_system.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -f files.f \
   --top-module tb_soc_system -o tb_soc_system > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_soc_system > sim.log 2>&1
grep -qxF '>>> PASS' sim.log && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
